/* verilog/ade9078_regs_pkg.sv */
package ade9078_regs_pkg;

  // ******************************
  // Register access types
  // ******************************

  // Device register address
  typedef logic [11:0] regAddr_t;

  // Register data word, 16-bit registers use the lower half
  typedef logic [31:0] regData_t;

  // Two-byte command header sent ahead of every access
  typedef logic [15:0] cmdHeader_t;

  // ******************************
  // Header bit layout
  // ******************************

  // Byte 0 carries address bits 11..4
  // Byte 1 carries address bits 3..0 in its upper nibble

  // Set for a read, clear for a write
  localparam int READ_FLAG_BIT = 3;

  // Address starts here within the header
  localparam int ADDR_SHIFT = 4;

endpackage

/* verilog/spi_frame_pkg.sv */
package spi_frame_pkg;

  // ******************************
  // Bus framing types
  // ******************************

  // One byte on the serial bus
  typedef logic [7:0] spiByte_t;

  // Byte count within a frame, at most 6
  typedef logic [2:0] byteCount_t;

  // Command header length in bytes
  localparam byteCount_t HEADER_BYTES = 3'd2;

  // ******************************
  // Shift engine
  // ******************************

  // Frame sequencing
  typedef enum logic [1:0] {
    Idle,
    Select,
    Shift,
    Release
  } shiftState_t;

  // Half period of the serial clock in system clocks
  localparam int DEFAULT_CLK_DIV = 4;

endpackage

/* verilog/spi_frame_if.sv */
interface spi_frame_if;

  // One formatted frame, valid on the frameStart cycle
  logic                          frameStart;
  ade9078_regs_pkg::cmdHeader_t  header;
  ade9078_regs_pkg::regData_t    payload;
  spi_frame_pkg::byteCount_t     dataBytes;
  logic                          isRead;
  logic                          absolute;

  modport decoder (
    output frameStart,
    output header,
    output payload,
    output dataBytes,
    output isRead,
    output absolute
  );

  modport engine (
    input frameStart,
    input header,
    input payload,
    input dataBytes,
    input isRead,
    input absolute
  );

endinterface

/* verilog/command_decode.sv */
module command_decode (
  input  logic                        clk,
  input  logic                        i_reset,
  input  logic                        i_start,
  input  ade9078_regs_pkg::regAddr_t  i_address,
  input  logic                        i_write,
  input  logic                        i_wide,
  input  logic                        i_absolute,
  input  ade9078_regs_pkg::regData_t  i_wrData,
  input  logic                        i_engineIdle,
  output logic                        o_busy,
  spi_frame_if.decoder                frame
);

  logic accept;
  logic readReq;

  assign accept  = i_start && !o_busy && i_engineIdle;
  assign readReq = ~i_write;

  // ******************************
  // Request tracking
  // ******************************

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_busy           <= 1'b0;
      frame.frameStart <= 1'b0;
    end
    else
    begin
      frame.frameStart <= accept;
      if (accept)
      begin
        o_busy <= 1'b1;
      end
      // Engine is back in idle once the frame has gone out
      else if (o_busy && i_engineIdle && !frame.frameStart)
      begin
        o_busy <= 1'b0;
      end
    end
  end

  // ******************************
  // Frame formatting
  // ******************************

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      frame.header <=
        (ade9078_regs_pkg::cmdHeader_t'(i_address) << ade9078_regs_pkg::ADDR_SHIFT) |
        (ade9078_regs_pkg::cmdHeader_t'(readReq) << ade9078_regs_pkg::READ_FLAG_BIT);
      // Reads clock out zeros, short writes sit in the upper half
      if (readReq)
      begin
        frame.payload <= '0;
      end
      else if (i_wide)
      begin
        frame.payload <= i_wrData;
      end
      else
      begin
        frame.payload <= {i_wrData[15:0], 16'h0000};
      end
      frame.dataBytes <= i_wide ? 3'd4 : 3'd2;
      frame.isRead    <= readReq;
      frame.absolute  <= i_absolute;
    end
  end

endmodule

/* verilog/spi_shift_engine.sv */
module spi_shift_engine #(
  parameter int CLK_DIV = spi_frame_pkg::DEFAULT_CLK_DIV
) (
  input  logic                     clk,
  input  logic                     i_reset,
  spi_frame_if.engine              frame,
  input  logic                     i_miso,
  output logic                     o_csN,
  output logic                     o_sclk,
  output logic                     o_mosi,
  output logic                     o_idle,
  output spi_frame_pkg::spiByte_t  o_rxByte,
  output logic                     o_rxValid,
  output logic                     o_frameEnd,
  output logic                     o_isRead,
  output logic                     o_absolute
);

  localparam int FRAME_BITS = $bits(ade9078_regs_pkg::cmdHeader_t) +
                              $bits(ade9078_regs_pkg::regData_t);
  localparam int DIV_W      = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(CLK_DIV - 1);

  spi_frame_pkg::shiftState_t  state;
  logic [DIV_W-1:0]            divCnt;
  logic [2:0]                  bitCnt;
  spi_frame_pkg::byteCount_t   byteCnt;
  spi_frame_pkg::byteCount_t   totalBytes;
  logic [FRAME_BITS-1:0]       txShift;
  spi_frame_pkg::spiByte_t     rxShift;

  logic sclkTick;
  logic riseTick;
  logic fallTick;
  logic byteDone;
  logic lastByte;

  assign o_idle   = (state == spi_frame_pkg::Idle);
  assign sclkTick = (state == spi_frame_pkg::Shift) && (divCnt == LAST_DIV);
  assign riseTick = sclkTick && !o_sclk;
  assign fallTick = sclkTick && o_sclk;
  assign byteDone = fallTick && (bitCnt == 3'd7);
  assign lastByte = byteDone && (byteCnt == totalBytes - 3'd1);

  // ******************************
  // Frame sequencing
  // ******************************

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      state      <= spi_frame_pkg::Idle;
      o_csN      <= 1'b1;
      o_sclk     <= 1'b0;
      o_mosi     <= 1'b0;
      divCnt     <= '0;
      bitCnt     <= '0;
      byteCnt    <= '0;
      totalBytes <= '0;
      o_rxValid  <= 1'b0;
      o_frameEnd <= 1'b0;
      o_isRead   <= 1'b0;
      o_absolute <= 1'b0;
    end
    else
    begin
      o_rxValid  <= 1'b0;
      o_frameEnd <= 1'b0;
      case (state)
        spi_frame_pkg::Idle:
        begin
          if (frame.frameStart)
          begin
            state      <= spi_frame_pkg::Select;
            o_csN      <= 1'b0;
            o_mosi     <= frame.header[15];
            divCnt     <= '0;
            bitCnt     <= '0;
            byteCnt    <= '0;
            totalBytes <= spi_frame_pkg::HEADER_BYTES + frame.dataBytes;
            o_isRead   <= frame.isRead;
            o_absolute <= frame.absolute;
          end
        end
        // One cycle of chip select setup before the first edge
        spi_frame_pkg::Select:
        begin
          state <= spi_frame_pkg::Shift;
        end
        spi_frame_pkg::Shift:
        begin
          if (sclkTick)
          begin
            divCnt <= '0;
            o_sclk <= ~o_sclk;
          end
          else
          begin
            divCnt <= divCnt + 1'b1;
          end
          // Mode 0 so the next bit goes out on the falling edge
          if (fallTick)
          begin
            bitCnt <= bitCnt + 3'd1;
            o_mosi <= lastByte ? 1'b0 : txShift[FRAME_BITS-2];
          end
          if (byteDone)
          begin
            byteCnt   <= byteCnt + 3'd1;
            o_rxValid <= o_isRead && (byteCnt >= spi_frame_pkg::HEADER_BYTES);
          end
          if (lastByte)
          begin
            state      <= spi_frame_pkg::Release;
            o_csN      <= 1'b1;
            o_frameEnd <= 1'b1;
          end
        end
        spi_frame_pkg::Release:
        begin
          state <= spi_frame_pkg::Idle;
        end
        default:
        begin
          state <= spi_frame_pkg::Idle;
        end
      endcase
    end
  end

  // ******************************
  // Data shifters
  // ******************************

  always_ff @(posedge clk)
  begin
    if (o_idle && frame.frameStart)
    begin
      txShift <= {frame.header, frame.payload};
    end
    else if (fallTick)
    begin
      txShift <= txShift << 1;
    end
    if (riseTick)
    begin
      rxShift <= {rxShift[6:0], i_miso};
    end
    if (byteDone)
    begin
      o_rxByte <= rxShift;
    end
  end

endmodule

/* verilog/read_result.sv */
module read_result (
  input  logic                        clk,
  input  logic                        i_reset,
  input  spi_frame_pkg::spiByte_t     i_rxByte,
  input  logic                        i_rxValid,
  input  logic                        i_frameEnd,
  input  logic                        i_isRead,
  input  logic                        i_absolute,
  output logic                        o_done,
  output ade9078_regs_pkg::regData_t  o_rdData
);

  ade9078_regs_pkg::regData_t  acc;
  ade9078_regs_pkg::regData_t  assembled;
  ade9078_regs_pkg::regData_t  result;
  spi_frame_pkg::byteCount_t   rxCount;
  spi_frame_pkg::byteCount_t   countNext;
  logic                        wide;
  logic [15:0]                 lowHalf;
  logic [15:0]                 lowNeg;

  // Last data byte arrives on the frame end cycle
  assign assembled = i_rxValid ? {acc[23:0], i_rxByte} : acc;
  assign countNext = i_rxValid ? rxCount + 3'd1 : rxCount;
  assign wide      = countNext > 3'd2;
  assign lowHalf   = assembled[15:0];
  assign lowNeg    = ~lowHalf + 16'd1;

  // ******************************
  // Sign handling
  // ******************************

  always_comb
  begin
    if (!i_absolute)
    begin
      result = assembled;
    end
    else if (wide)
    begin
      result = assembled[31] ? (~assembled + 32'd1) : assembled;
    end
    else
    begin
      result = lowHalf[15] ? {16'h0000, lowNeg} : assembled;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      acc     <= '0;
      rxCount <= '0;
      o_done  <= 1'b0;
    end
    else
    begin
      o_done <= i_frameEnd;
      if (i_frameEnd)
      begin
        acc     <= '0;
        rxCount <= '0;
      end
      else if (i_rxValid)
      begin
        acc     <= assembled;
        rxCount <= countNext;
      end
    end
  end

  // Writes leave the last read value in place
  always_ff @(posedge clk)
  begin
    if (i_frameEnd && i_isRead)
    begin
      o_rdData <= result;
    end
  end

endmodule

/* verilog/ade9078_spi_top.sv */
module ade9078_spi_top #(
  parameter int CLK_DIV = spi_frame_pkg::DEFAULT_CLK_DIV
) (
  input  logic                        clk,
  input  logic                        i_reset,
  input  logic                        i_start,
  input  ade9078_regs_pkg::regAddr_t  i_address,
  input  logic                        i_write,
  input  logic                        i_wide,
  input  logic                        i_absolute,
  input  ade9078_regs_pkg::regData_t  i_wrData,
  input  logic                        i_miso,
  output logic                        o_busy,
  output logic                        o_done,
  output ade9078_regs_pkg::regData_t  o_rdData,
  output logic                        o_csN,
  output logic                        o_sclk,
  output logic                        o_mosi
);

  logic                     engineIdle;
  spi_frame_pkg::spiByte_t  rxByte;
  logic                     rxValid;
  logic                     frameEnd;
  logic                     isRead;
  logic                     absolute;

  spi_frame_if frameBus ();

  command_decode u_decode (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_start      (i_start),
    .i_address    (i_address),
    .i_write      (i_write),
    .i_wide       (i_wide),
    .i_absolute   (i_absolute),
    .i_wrData     (i_wrData),
    .i_engineIdle (engineIdle),
    .o_busy       (o_busy),
    .frame        (frameBus.decoder)
  );

  spi_shift_engine #(
    .CLK_DIV (CLK_DIV)
  ) u_engine (
    .clk        (clk),
    .i_reset    (i_reset),
    .frame      (frameBus.engine),
    .i_miso     (i_miso),
    .o_csN      (o_csN),
    .o_sclk     (o_sclk),
    .o_mosi     (o_mosi),
    .o_idle     (engineIdle),
    .o_rxByte   (rxByte),
    .o_rxValid  (rxValid),
    .o_frameEnd (frameEnd),
    .o_isRead   (isRead),
    .o_absolute (absolute)
  );

  read_result u_result (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rxByte   (rxByte),
    .i_rxValid  (rxValid),
    .i_frameEnd (frameEnd),
    .i_isRead   (isRead),
    .i_absolute (absolute),
    .o_done     (o_done),
    .o_rdData   (o_rdData)
  );

endmodule

/* testbench/ade9078_spi_model.sv */
module ade9078_spi_model (
  input  logic i_csN,
  input  logic i_sclk,
  input  logic i_mosi,
  input  logic i_wide,
  output logic o_miso
);

  logic [31:0] regStore [logic [11:0]];
  logic [15:0] header;
  logic [31:0] rxWord;
  logic [31:0] txWord;
  logic [31:0] word;
  logic        prevCsN;
  logic        prevSclk;
  int          bitCount;

  // Unwritten registers answer with a pattern built from their address
  function automatic logic [31:0] defaultWord(input logic [11:0] addr);
    return {addr, 4'hA, addr, 4'h5};
  endfunction

  initial
  begin
    o_miso   = 1'b0;
    prevCsN  = 1'b1;
    prevSclk = 1'b0;
    bitCount = 0;
    header   = '0;
  end

  // Mode 0 slave, sample on rising edge and drive on falling edge
  always @(i_csN or i_sclk)
  begin
    if (prevCsN === 1'b1 && i_csN === 1'b0)
    begin
      bitCount = 0;
      header   = '0;
      rxWord   = '0;
      txWord   = '0;
      o_miso   = 1'b0;
    end
    else if (prevCsN === 1'b0 && i_csN === 1'b1)
    begin
      if (!header[3] && bitCount > 16)
        regStore[header[15:4]] = i_wide ? rxWord : {16'h0000, rxWord[15:0]};
      o_miso = 1'b0;
    end
    else if (i_csN === 1'b0 && prevSclk === 1'b0 && i_sclk === 1'b1)
    begin
      if (bitCount < 16)
        header = {header[14:0], i_mosi};
      else
        rxWord = {rxWord[30:0], i_mosi};
      bitCount = bitCount + 1;
      if (bitCount == 16 && header[3])
      begin
        word = regStore.exists(header[15:4]) ? regStore[header[15:4]]
                                             : defaultWord(header[15:4]);
        txWord = i_wide ? word : {word[15:0], 16'h0000};
      end
    end
    else if (i_csN === 1'b0 && prevSclk === 1'b1 && i_sclk === 1'b0 && bitCount >= 16)
    begin
      o_miso = txWord[31];
      txWord = txWord << 1;
    end
    prevCsN  = i_csN;
    prevSclk = i_sclk;
  end

endmodule

/* testbench/ade9078_properties.sv */
module ade9078_properties (
  input logic clk,
  input logic i_reset,
  input logic i_start,
  input logic i_wide,
  input logic i_busy,
  input logic i_done,
  input logic i_csN,
  input logic i_sclk
);

  int unsigned failCount = 0;
  int unsigned pending;
  int unsigned sclkRises;
  logic        prevSclk;
  logic        frameWide;
  logic        accept;

  assign accept = i_start && !i_busy;

  // ******************************
  // Frame bookkeeping
  // ******************************

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      pending   <= 0;
      sclkRises <= 0;
      prevSclk  <= 1'b0;
      frameWide <= 1'b0;
    end
    else
    begin
      prevSclk <= i_sclk;
      if (accept)
      begin
        frameWide <= i_wide;
        sclkRises <= 0;
        pending   <= pending + 1;
      end
      else
      begin
        if (i_sclk && !prevSclk)
          sclkRises <= sclkRises + 1;
        if (i_done)
          pending <= pending - 1;
      end
    end
  end

  // ******************************
  // Bus and handshake rules
  // ******************************

  afterReset: assert property (@(posedge clk)
    $fell(i_reset) |-> i_csN && !i_sclk && !i_busy && !i_done)
    else begin failCount++; $error("outputs not at rest after reset"); end

  idleClock: assert property (@(posedge clk) disable iff (i_reset) i_csN |-> !i_sclk)
    else begin failCount++; $error("serial clock high with chip select released"); end

  busyRise: assert property (@(posedge clk) disable iff (i_reset) accept |=> i_busy)
    else begin failCount++; $error("busy did not rise after an accepted start"); end

  // Busy may only fall after the done pulse
  busyHold: assert property (@(posedge clk) disable iff (i_reset)
    i_busy && !i_done |=> i_busy)
    else begin failCount++; $error("busy dropped before done"); end

  donePulse: assert property (@(posedge clk) disable iff (i_reset) i_done |=> !i_done)
    else begin failCount++; $error("done held longer than one cycle"); end

  doneBusy: assert property (@(posedge clk) disable iff (i_reset) i_done |-> i_busy)
    else begin failCount++; $error("done without busy"); end

  oneDone: assert property (@(posedge clk) disable iff (i_reset) i_done |-> pending == 1)
    else begin failCount++; $error("done count differs from accepted starts"); end

  selectInFrame: assert property (@(posedge clk) disable iff (i_reset) $fell(i_csN) |-> i_busy)
    else begin failCount++; $error("chip select fell outside a request"); end

  // Two header bytes plus two or four data bytes
  edgeCount: assert property (@(posedge clk) disable iff (i_reset)
    $rose(i_csN) |-> sclkRises == (frameWide ? 48 : 32))
    else begin failCount++; $error("wrong number of serial clock edges in frame"); end

endmodule

/* testbench/tb_ade9078.sv */
module tb_ade9078;

  localparam int CLK_DIV          = spi_frame_pkg::DEFAULT_CLK_DIV;
  localparam int RESET_CYCLES     = 16;
  localparam int MAX_LATENCY      = 3 + 6 * 16 * CLK_DIV;
  localparam int NUM_TRANSACTIONS = 21;
  localparam int TIMEOUT_CYCLES   = NUM_TRANSACTIONS * MAX_LATENCY * 2;

  logic                        clk;
  logic                        i_reset;
  logic                        i_start;
  ade9078_regs_pkg::regAddr_t  i_address;
  logic                        i_write;
  logic                        i_wide;
  logic                        i_absolute;
  ade9078_regs_pkg::regData_t  i_wrData;
  logic                        miso;
  logic                        o_busy;
  logic                        o_done;
  ade9078_regs_pkg::regData_t  o_rdData;
  logic                        o_csN;
  logic                        o_sclk;
  logic                        o_mosi;

  int          cycleCount = 0;
  int          errorCount = 0;
  int          checkCount = 0;
  int          testCount  = 0;
  logic [31:0] lcgState   = 32'heffc696d;

  ade9078_spi_top #(
    .CLK_DIV (CLK_DIV)
  ) u_dut (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_start    (i_start),
    .i_address  (i_address),
    .i_write    (i_write),
    .i_wide     (i_wide),
    .i_absolute (i_absolute),
    .i_wrData   (i_wrData),
    .i_miso     (miso),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_rdData   (o_rdData),
    .o_csN      (o_csN),
    .o_sclk     (o_sclk),
    .o_mosi     (o_mosi)
  );

  ade9078_spi_model u_model (
    .i_csN  (o_csN),
    .i_sclk (o_sclk),
    .i_mosi (o_mosi),
    .i_wide (i_wide),
    .o_miso (miso)
  );

  bind ade9078_spi_top ade9078_properties u_props (
    .clk     (clk),
    .i_reset (i_reset),
    .i_start (i_start),
    .i_wide  (i_wide),
    .i_busy  (o_busy),
    .i_done  (o_done),
    .i_csN   (o_csN),
    .i_sclk  (o_sclk)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: no done after %0d cycles", cycleCount);
      $display("Checks failed");
      $finish;
    end
  end

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic ade9078_regs_pkg::regAddr_t randomAddress();
    logic [31:0] r;
    r = nextRandom();
    return r[31:20];
  endfunction

  // Model answer for an unwritten register cut to the frame width
  function automatic logic [31:0] patternFor(input logic [11:0] addr, input logic wide);
    logic [31:0] word;
    word = {addr, 4'hA, addr, 4'h5};
    return wide ? word : {16'h0000, word[15:0]};
  endfunction

  function automatic logic [31:0] magnitude(input logic [31:0] value, input logic wide);
    logic [15:0] low;
    low = value[15:0];
    if (wide)
      return value[31] ? (32'd0 - value) : value;
    return {16'h0000, low[15] ? (16'd0 - low) : low};
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] want);
    checkCount++;
    assert (got === want)
    else
    begin
      errorCount++;
      $display("** Error at %0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, want);
    end
  endtask

  task automatic runTransfer(input logic write, input logic wide, input logic absolute,
                             input logic [11:0] addr, input logic [31:0] data,
                             input logic pokeWhileBusy, output logic [31:0] rdData);
    @(posedge clk);
    i_start    <= 1'b1;
    i_address  <= addr;
    i_write    <= write;
    i_wide     <= wide;
    i_absolute <= absolute;
    i_wrData   <= data;
    @(posedge clk);
    i_start <= 1'b0;
    // A second start while busy must be ignored
    if (pokeWhileBusy)
    begin
      repeat (3) @(posedge clk);
      i_start   <= 1'b1;
      i_address <= ~addr;
      @(posedge clk);
      i_start <= 1'b0;
    end
    @(posedge clk);
    while (o_done !== 1'b1)
      @(posedge clk);
    rdData = o_rdData;
  endtask

  task automatic writeReg(input logic [11:0] addr, input logic [31:0] data, input logic wide);
    logic [31:0] unused;
    runTransfer(1'b1, wide, 1'b0, addr, data, 1'b0, unused);
  endtask

  task automatic readCheck(input string what, input logic [11:0] addr, input logic wide,
                           input logic absolute, input logic [31:0] want);
    logic [31:0] got;
    runTransfer(1'b0, wide, absolute, addr, nextRandom(), 1'b0, got);
    checkValue(what, got, want);
  endtask

  task automatic absCheck(input logic [31:0] data, input logic wide);
    logic [11:0] addr;
    addr = randomAddress();
    writeReg(addr, data, wide);
    readCheck("magnitude read", addr, wide, 1'b1, magnitude(data, wide));
  endtask

  task automatic watchQuiet(input int cycles);
    int activity;
    activity = 0;
    repeat (cycles)
    begin
      @(posedge clk);
      if (o_csN !== 1'b1 || o_done !== 1'b0)
        activity++;
    end
    checkValue("bus activity after ignored start", activity, 0);
  endtask

  task automatic endTest(input string name, input int errorsBefore);
    testCount++;
    $display("Test %0d %s: %s", testCount, name,
             (errorCount == errorsBefore) ? "ok" : "mismatch");
  endtask

  // ******************************
  // Stimulus
  // ******************************

  initial
  begin
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] unused;
    logic [31:0] rdData;
    logic [31:0] lastRead;
    int          errorsBefore;
    int          totalErrors;
    clk        = 1'b0;
    i_reset    = 1'b1;
    i_start    = 1'b0;
    i_address  = '0;
    i_write    = 1'b0;
    i_wide     = 1'b0;
    i_absolute = 1'b0;
    i_wrData   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    i_reset <= 1'b0;
    @(posedge clk);

    errorsBefore = errorCount;
    checkValue("chip select after reset", {31'd0, o_csN}, 32'd1);
    checkValue("serial clock after reset", {31'd0, o_sclk}, 32'd0);
    checkValue("serial data after reset", {31'd0, o_mosi}, 32'd0);
    checkValue("busy after reset", {31'd0, o_busy}, 32'd0);
    checkValue("done after reset", {31'd0, o_done}, 32'd0);
    endTest("reset state", errorsBefore);

    errorsBefore = errorCount;
    repeat (2)
    begin
      addr = randomAddress();
      readCheck("default 32-bit read", addr, 1'b1, 1'b0, patternFor(addr, 1'b1));
      readCheck("default 16-bit read", addr, 1'b0, 1'b0, patternFor(addr, 1'b0));
    end
    endTest("default pattern reads", errorsBefore);

    errorsBefore = errorCount;
    addr = randomAddress();
    data = nextRandom();
    writeReg(addr, data, 1'b0);
    lastRead = {16'h0000, data[15:0]};
    readCheck("16-bit readback", addr, 1'b0, 1'b0, lastRead);
    addr = randomAddress();
    data = nextRandom();
    // Read data must survive a write
    runTransfer(1'b1, 1'b1, 1'b0, addr, data, 1'b0, rdData);
    checkValue("read data after write", rdData, lastRead);
    readCheck("32-bit readback", addr, 1'b1, 1'b0, data);
    endTest("write then read", errorsBefore);

    errorsBefore = errorCount;
    absCheck(nextRandom() | 32'h80000000, 1'b1);
    absCheck(nextRandom() & 32'h7fffffff, 1'b1);
    absCheck(nextRandom() | 32'h00008000, 1'b0);
    absCheck(nextRandom() & 32'hffff7fff, 1'b0);
    absCheck(32'h80000000, 1'b1);
    endTest("magnitude reads", errorsBefore);

    errorsBefore = errorCount;
    addr = randomAddress();
    data = nextRandom();
    runTransfer(1'b1, 1'b1, 1'b0, addr, data, 1'b1, unused);
    watchQuiet(MAX_LATENCY);
    readCheck("readback after ignored start", addr, 1'b1, 1'b0, data);
    endTest("start during busy", errorsBefore);

    totalErrors = errorCount + u_dut.u_props.failCount;
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             testCount, checkCount, errorCount, u_dut.u_props.failCount);
    if (totalErrors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* project.f */
verilog/ade9078_regs_pkg.sv
verilog/spi_frame_pkg.sv
verilog/spi_frame_if.sv
verilog/command_decode.sv
verilog/spi_shift_engine.sv
verilog/read_result.sv
verilog/ade9078_spi_top.sv
testbench/ade9078_spi_model.sv
testbench/ade9078_properties.sv
testbench/tb_ade9078.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ade9078
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
